//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -rf obj_dir
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module core_tb -o core_tb
	./obj_dir/core_tb | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int inst_addr_width = 6;
	localparam string vector_file = "bench/core_vectors.txt";

	logic                       clk;
	logic                       rst_n;
	logic                       sw_load;
	logic                       sw_exec;
	logic                       load_valid;
	logic [31:0]                load_word;
	logic                       out_ready;
	logic                       out_valid;
	logic [7:0]                 out_data;
	logic                       halted;
	logic [inst_addr_width-1:0] pc;

	byte         cmd_q [$];
	logic [31:0] arg_q [$];
	logic [7:0]  exp_q [$];
	int          n_lines = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	logic        loaded = 1'b0;
	logic [31:0] rnd_state;

	core_top #(
		.inst_addr_width(inst_addr_width),
		.rs_depth(2),
		.out_depth(2)
	) i_core_top (
		.clk,
		.rst_n,
		.sw_load,
		.sw_exec,
		.load_valid,
		.load_word,
		.out_ready,
		.out_valid,
		.out_data,
		.halted,
		.pc
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// vector file

	task automatic read_vectors(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [31:0] val;
		fd = $fopen(vector_file, "r");
		ok = fd != 0;
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#" && line[0] != "\n") begin
					val = '0;
					// wait counts are decimal, words and bytes hex
					if (line[0] == "W") begin
						n = $sscanf(line.substr(1, line.len() - 1), "%d", val);
					end else begin
						n = $sscanf(line.substr(1, line.len() - 1), "%h", val);
					end
					cmd_q.push_back(line[0]);
					arg_q.push_back(val);
					n_lines++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic load_instruction(input logic [31:0] word);
		@(posedge clk);
		load_valid <= 1'b1;
		load_word <= word;
		@(posedge clk);
		load_valid <= 1'b0;
	endtask

	task automatic enter_exec();
		@(posedge clk);
		sw_load <= 1'b0;
		sw_exec <= 1'b1;
		// program is over once halt sits at issue and every byte came out
		@(negedge clk);
		while (!(halted && exp_q.size() == 0)) begin
			@(negedge clk);
		end
	endtask

	task automatic return_to_load();
		@(negedge clk);
		check_value("halted", halted, 32'd1);
		@(posedge clk);
		sw_load <= 1'b1;
		sw_exec <= 1'b0;
		// mode register follows one edge after the switch
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("halted", halted, 32'd0);
		check_value("pc", pc, 32'd0);
	endtask

	task automatic run_command(input byte cmd, input logic [31:0] arg);
		case (cmd)
			"L": load_instruction(arg);
			"E": enter_exec();
			"R": return_to_load();
			"W": repeat (arg) @(posedge clk);
			"O": exp_q.push_back(arg[7:0]);
			default: begin
				n_errors++;
				$display("unknown command %c in the vector file", cmd);
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus and result

	initial begin
		bit ok;
		rst_n <= 1'b0;
		sw_load <= 1'b1;
		sw_exec <= 1'b0;
		load_valid <= 1'b0;
		load_word <= '0;
		read_vectors(ok);
		if (!ok) begin
			$display("could not open %s for reading", vector_file);
			$display("Test failed");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (4) @(posedge clk);
			rst_n <= 1'b1;
			while (cmd_q.size() != 0) begin
				run_command(cmd_q.pop_front(), arg_q.pop_front());
			end
			repeat (4) @(posedge clk);
			@(negedge clk);
			check_value("halted", halted, 32'd1);
			if (exp_q.size() != 0) begin
				n_errors++;
				$display("%0d expected output bytes never appeared", exp_q.size());
			end
			$display("%0d checks, %0d errors", n_checks, n_errors);
			if (n_errors == 0) begin
				$display("Test completed successfully");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	// random back-pressure on the output port
	initial begin
		rnd_state = 32'd997;
		out_ready <= 1'b0;
		forever begin
			@(posedge clk);
			rnd_state = xorshift(rnd_state);
			out_ready <= rnd_state[0];
		end
	end

	// outputs hold for the whole cycle, so look at them mid-cycle
	initial begin
		forever begin
			@(negedge clk);
			if (rst_n && out_valid) begin
				if (!out_ready) begin
					n_errors++;
					$display("output strobe high while out_ready is low, byte 0x%02h", out_data);
				end
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("unexpected output byte 0x%02h with nothing left to expect",
						out_data);
				end else begin
					check_value("out_data", out_data, exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (n_lines * 300) @(posedge clk);
		$display("run did not finish within %0d cycles, stopped by the watchdog",
			n_lines * 300);
		$display("Test failed");
		$finish;
	end

endmodule

//--- bench/core_vectors.txt
# L word (hex) loads one instruction, O byte (hex) queues an expected output
# E enters exec and waits for halt, W count (decimal) idles, R returns to load mode
L 32000123 # addi r1, r0, 0x123
L 34000055 # addi r2, r0, 0x55
L 16500000 # add r3, r1, r2
L 40C00000 # out r3
L 28880000 # sub r4, r2, r1
L 41000000 # out r4
L 3A40FE00 # addi r5, r1, -0x200
L 41400000 # out r5
L 3C400010 # addi r6, r1, 0x10
L 1D900000 # add r6, r6, r2
L 2D980000 # sub r6, r6, r3
L 3D80FFF1 # addi r6, r6, -15
L 41800000 # out r6
L 3E000011 # addi r7, r0, 0x11
L 3E0000C3 # addi r7, r0, 0xc3
L 17F80000 # add r3, r7, r7
L 40C00000 # out r3
L 41C00000 # out r7
L F0000000 # halt
O 78
O 32
O 23
O 01
O 86
O C3
E
W 20
R
L 32000040 # addi r1, r0, 0x40
L 3440FFFF # addi r2, r1, -1
L 26500000 # sub r3, r1, r2
L 40800000 # out r2
L 40C00000 # out r3
L 40400000 # out r1
L F0000000 # halt
O 3F
O 01
O 40
E
W 20

//--- sources.f
src/ooo_pkg.sv
src/inst_mem.sv
src/register_file.sv
src/rob.sv
src/add_sub.sv
src/commit_ring.sv
src/out_unit.sv
src/core_top.sv
bench/core_tb.sv

//--- src/add_sub.sv
`timescale 1ns/1ps

module add_sub #(
	parameter int rs_depth = 2
) (
	input  logic            clk,
	input  logic            rst_n,
	input  ooo_pkg::issue_t issue,
	output logic            ready,
	input  ooo_pkg::cdb_t   cdb,
	output ooo_pkg::cdb_t   result
);

	// entries stay packed toward index 0, oldest first
	ooo_pkg::issue_t     rs [rs_depth];
	ooo_pkg::issue_t     rs_next [rs_depth];
	ooo_pkg::issue_t     pick;
	logic [rs_depth-1:0] occupied;
	logic                fire;
	int                  sel;
	logic [31:0]         sum;

	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			occupied[i] = rs[i].valid;
		end
	end

	assign ready = !occupied[rs_depth-1];

	// scan down so the lowest ready index wins
	always_comb begin
		fire = 1'b0;
		sel = 0;
		pick = rs[0];
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if (rs[i].valid && rs[i].a.ready && rs[i].b.ready) begin
				fire = 1'b1;
				sel = i;
				pick = rs[i];
			end
		end
	end

	always_comb begin
		int k;
		k = 0;
		for (int i = 0; i < rs_depth; i++) begin
			rs_next[i] = '0;
		end
		for (int i = 0; i < rs_depth; i++) begin
			if (rs[i].valid && !(fire && i == sel)) begin
				rs_next[k] = rs[i];
				rs_next[k].a = ooo_pkg::snoop(rs[i].a, cdb);
				rs_next[k].b = ooo_pkg::snoop(rs[i].b, cdb);
				k++;
			end
		end
		if (issue.valid && ready) begin
			rs_next[k] = issue;
			rs_next[k].a = ooo_pkg::snoop(issue.a, cdb);
			rs_next[k].b = ooo_pkg::snoop(issue.b, cdb);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < rs_depth; i++) begin
				rs[i].valid <= 1'b0;
			end
		end else begin
			rs <= rs_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// execute stage drives the cdb one cycle after dispatch

	always_comb begin
		case (pick.op)
			ooo_pkg::op_sub:  sum = pick.a.data - pick.b.data;
			ooo_pkg::op_addi: sum = pick.a.data + {{16{pick.imm[15]}}, pick.imm};
			default:          sum = pick.a.data + pick.b.data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= fire;
		end
		result.tag <= pick.tag;
		result.data <= sum;
	end

	// an accepted issue must land in a free slot
	a_no_issue_full: assert property (@(posedge clk) disable iff (!rst_n)
		issue.valid && ready |=>
			$countones(occupied) == $past($countones(occupied)) + 1 - $past(fire))
		else $error("station accepted while full");

endmodule

//--- src/commit_ring.sv
`timescale 1ns/1ps

module commit_ring (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  ooo_pkg::commit_kind_t push_kind,
	output logic                  full,
	output ooo_pkg::commit_kind_t head_kind,
	output logic                  empty,
	input  logic                  pop
);

	localparam int depth = 2 ** ooo_pkg::rob_width;

	ooo_pkg::commit_kind_t         kinds [depth];
	logic [ooo_pkg::rob_width-1:0] head;
	logic [ooo_pkg::rob_width-1:0] tail;
	logic [ooo_pkg::rob_width:0]   count;

	assign full = count[ooo_pkg::rob_width];
	assign empty = count == '0;
	assign head_kind = kinds[head];

	always_ff @(posedge clk) begin
		if (push) begin
			kinds[tail] <= push_kind;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push) tail <= tail + 1'b1;
			if (pop) head <= head + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_ring_bounds: assert property (@(posedge clk) disable iff (!rst_n)
		!(push && full) && !(pop && empty)) else $error("commit ring overflow or underflow");

endmodule

//--- src/core_top.sv
`timescale 1ns/1ps

module core_top #(
	parameter int inst_addr_width = 6,
	parameter int rs_depth = 2,
	parameter int out_depth = 2
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       sw_load,
	input  logic                       sw_exec,
	input  logic                       load_valid,
	input  logic [31:0]                load_word,
	input  logic                       out_ready,
	output logic                       out_valid,
	output logic [7:0]                 out_data,
	output logic                       halted,
	output logic [inst_addr_width-1:0] pc
);

	typedef enum logic {
		mode_load,
		mode_exec
	} mode_t;

	mode_t                         mode;
	mode_t                         next_mode;
	logic                          mode_change;
	logic                          mode_changed;
	logic                          exec;
	ooo_pkg::inst_t                inst;
	logic                          stall;
	logic                          is_alu;
	logic                          is_out;
	logic                          rob_full;
	logic                          ring_full;
	logic                          ring_empty;
	logic [ooo_pkg::rob_width-1:0] new_tag;
	ooo_pkg::issue_t               req;
	ooo_pkg::issue_t               alu_issue;
	ooo_pkg::issue_t               out_issue;
	logic                          alu_ready;
	logic                          oq_ready;
	logic                          alu_accept;
	logic                          out_accept;
	logic                          accept;
	ooo_pkg::operand_t             arch_a;
	ooo_pkg::operand_t             arch_b;
	ooo_pkg::cdb_t                 rob_a;
	ooo_pkg::cdb_t                 rob_b;
	ooo_pkg::cdb_t                 cdb;
	ooo_pkg::commit_kind_t         head_kind;
	logic                          rob_commit;
	logic [2:0]                    commit_rd;
	logic [ooo_pkg::rob_width-1:0] commit_tag;
	logic [31:0]                   commit_data;
	logic                          out_done;

	////////////////////////////////////////////////////////////////////////////
	// mode

	assign next_mode = sw_load ? mode_load : sw_exec ? mode_exec : mode;
	assign mode_change = next_mode != mode;
	// first exec cycle waits for the fetch register
	assign exec = mode == mode_exec && !mode_changed;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mode <= mode_load;
			mode_changed <= 1'b0;
			halted <= 1'b0;
		end else begin
			mode <= next_mode;
			mode_changed <= mode_change;
			if (mode_change) begin
				halted <= 1'b0;
			end else if (exec && inst.op == ooo_pkg::op_halt) begin
				halted <= 1'b1;
			end
		end
	end

	// halt and unknown ops are never accepted, so fetch stops there
	assign stall = (mode == mode_load) ? !load_valid : exec && !accept;

	inst_mem #(.inst_addr_width(inst_addr_width)) i_inst_mem (
		.clk,
		.rst_n,
		.we(mode == mode_load && load_valid),
		.word(load_word),
		.reset_pc(mode_change),
		.stall,
		.pc,
		.inst
	);

	////////////////////////////////////////////////////////////////////////////
	// decode, operand merge, issue

	assign is_alu = inst.op inside {ooo_pkg::op_add, ooo_pkg::op_sub, ooo_pkg::op_addi};
	assign is_out = inst.op == ooo_pkg::op_out;

	// arch value, else finished rob entry, else result on the cdb right now
	function automatic ooo_pkg::operand_t merge(
		input ooo_pkg::operand_t arch,
		input ooo_pkg::cdb_t     entry,
		input ooo_pkg::cdb_t     bus
	);
		ooo_pkg::operand_t m;
		m = arch;
		if (!arch.ready && entry.valid) begin
			m.ready = 1'b1;
			m.data = entry.data;
		end
		return ooo_pkg::snoop(m, bus);
	endfunction

	always_comb begin
		req.valid = 1'b0;
		req.op = inst.op;
		req.tag = new_tag;
		req.a = merge(arch_a, rob_a, cdb);
		req.b = merge(arch_b, rob_b, cdb);
		req.imm = inst.imm;
		// addi takes no second register
		if (inst.op == ooo_pkg::op_addi) begin
			req.b.ready = 1'b1;
		end
		alu_issue = req;
		alu_issue.valid = exec && is_alu && !rob_full && !ring_full;
		out_issue = req;
		out_issue.valid = exec && is_out && !ring_full;
	end

	assign alu_accept = alu_issue.valid && alu_ready;
	assign out_accept = out_issue.valid && oq_ready;
	assign accept = alu_accept || out_accept;

	register_file i_register_file (
		.clk,
		.rst_n,
		.rs1(inst.rs1),
		.rs2(inst.rs2),
		.read_a(arch_a),
		.read_b(arch_b),
		.issue(alu_accept),
		.issue_rd(inst.rd),
		.issue_tag(new_tag),
		.commit(rob_commit),
		.commit_rd,
		.commit_tag,
		.commit_data
	);

	rob i_rob (
		.clk,
		.rst_n,
		.issue(alu_accept),
		.issue_rd(inst.rd),
		.issue_tag(new_tag),
		.full(rob_full),
		.read_tag_a(arch_a.tag),
		.read_tag_b(arch_b.tag),
		.read_a(rob_a),
		.read_b(rob_b),
		.cdb,
		.commit_kind(head_kind),
		.commit(rob_commit),
		.commit_rd,
		.commit_tag,
		.commit_data
	);

	add_sub #(.rs_depth(rs_depth)) i_add_sub (
		.clk,
		.rst_n,
		.issue(alu_issue),
		.ready(alu_ready),
		.cdb,
		.result(cdb)
	);

	////////////////////////////////////////////////////////////////////////////
	// commit order

	commit_ring i_commit_ring (
		.clk,
		.rst_n,
		.push(accept),
		.push_kind(is_out ? ooo_pkg::commit_out : ooo_pkg::commit_gpr),
		.full(ring_full),
		.head_kind,
		.empty(ring_empty),
		.pop(rob_commit || out_done)
	);

	out_unit #(.out_depth(out_depth)) i_out_unit (
		.clk,
		.rst_n,
		.issue(out_issue),
		.ready(oq_ready),
		.cdb,
		.grant(!ring_empty && head_kind == ooo_pkg::commit_out),
		.out_ready,
		.out_valid,
		.out_data,
		.done(out_done)
	);

endmodule

//--- src/inst_mem.sv
`timescale 1ns/1ps

module inst_mem #(
	parameter int inst_addr_width = 6
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       we,
	input  ooo_pkg::inst_t             word,
	input  logic                       reset_pc,
	input  logic                       stall,
	output logic [inst_addr_width-1:0] pc,
	output ooo_pkg::inst_t             inst
);

	ooo_pkg::inst_t mem [2**inst_addr_width];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[pc] <= word;
		end
	end

	// fetch register holds the word at issue
	always_ff @(posedge clk) begin
		if (!stall) begin
			inst <= mem[pc];
		end
	end

	// pc runs one word ahead of inst in exec mode
	always_ff @(posedge clk) begin
		if (!rst_n || reset_pc) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

endmodule

//--- src/ooo_pkg.sv
package ooo_pkg;

	localparam int rob_width = 3;

	typedef enum logic [3:0] {
		op_add  = 4'h1,
		op_sub  = 4'h2,
		op_addi = 4'h3,
		op_out  = 4'h4,
		op_halt = 4'hf
	} opcode_t;

	// op in the top nibble, imm in the low half
	typedef struct packed {
		opcode_t            op;
		logic [2:0]         rd;
		logic [2:0]         rs1;
		logic [2:0]         rs2;
		logic [2:0]         spare;
		logic signed [15:0] imm;
	} inst_t;

	typedef struct packed {
		logic                 valid;
		logic [rob_width-1:0] tag;
		logic [31:0]          data;
	} cdb_t;

	// data when ready, otherwise the producer tag
	typedef struct packed {
		logic                 ready;
		logic [rob_width-1:0] tag;
		logic [31:0]          data;
	} operand_t;

	typedef enum logic {
		commit_gpr,
		commit_out
	} commit_kind_t;

	typedef struct packed {
		logic                 valid;
		opcode_t              op;
		logic [rob_width-1:0] tag;
		operand_t             a;
		operand_t             b;
		logic signed [15:0]   imm;
	} issue_t;

	// pick up a broadcast result for a waiting operand
	function automatic operand_t snoop(operand_t opnd, cdb_t bus);
		operand_t r;
		r = opnd;
		if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
			r.ready = 1'b1;
			r.data = bus.data;
		end
		return r;
	endfunction

endpackage

//--- src/out_unit.sv
`timescale 1ns/1ps

module out_unit #(
	parameter int out_depth = 2
) (
	input  logic            clk,
	input  logic            rst_n,
	input  ooo_pkg::issue_t issue,
	output logic            ready,
	input  ooo_pkg::cdb_t   cdb,
	input  logic            grant,
	input  logic            out_ready,
	output logic            out_valid,
	output logic [7:0]      out_data,
	output logic            done
);

	localparam int ptr_width = $clog2(out_depth);
	localparam logic [ptr_width-1:0] last_slot = ptr_width'(out_depth - 1);
	localparam logic [ptr_width:0] full_count = (ptr_width + 1)'(out_depth);

	ooo_pkg::operand_t    q [out_depth];
	logic [ptr_width-1:0] head;
	logic [ptr_width-1:0] tail;
	logic [ptr_width:0]   count;
	logic                 push;

	assign ready = count != full_count;
	assign push = issue.valid && ready;

	// leaves only with the ring grant and the port free
	assign out_valid = grant && count != '0 && q[head].ready && out_ready;
	assign out_data = q[head].data[7:0];
	assign done = out_valid;

	always_ff @(posedge clk) begin
		for (int i = 0; i < out_depth; i++) begin
			q[i] <= ooo_pkg::snoop(q[i], cdb);
		end
		if (push) begin
			q[tail] <= ooo_pkg::snoop(issue.a, cdb);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push) tail <= (tail == last_slot) ? '0 : tail + 1'b1;
			if (out_valid) head <= (head == last_slot) ? '0 : head + 1'b1;
			count <= count + push - out_valid;
		end
	end

	// pointers must agree that the head slot holds an entry
	a_out_handshake: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_ready && (head != tail || count == full_count))
		else $error("output without ready or entry");

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [2:0]                    rs1,
	input  logic [2:0]                    rs2,
	output ooo_pkg::operand_t             read_a,
	output ooo_pkg::operand_t             read_b,
	input  logic                          issue,
	input  logic [2:0]                    issue_rd,
	input  logic [ooo_pkg::rob_width-1:0] issue_tag,
	input  logic                          commit,
	input  logic [2:0]                    commit_rd,
	input  logic [ooo_pkg::rob_width-1:0] commit_tag,
	input  logic [31:0]                   commit_data
);

	logic [31:0]                   data [8];
	logic [ooo_pkg::rob_width-1:0] tag [8];
	logic [7:0]                    busy;

	assign read_a = '{ready: !busy[rs1], tag: tag[rs1], data: data[rs1]};
	assign read_b = '{ready: !busy[rs2], tag: tag[rs2], data: data[rs2]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
			for (int i = 0; i < 8; i++) begin
				data[i] <= '0;
				tag[i] <= '0;
			end
		end else begin
			if (commit) begin
				data[commit_rd] <= commit_data;
				// a newer rename keeps rd busy
				if (tag[commit_rd] == commit_tag) begin
					busy[commit_rd] <= 1'b0;
				end
			end
			if (issue) begin
				busy[issue_rd] <= 1'b1;
				tag[issue_rd] <= issue_tag;
			end
		end
	end

endmodule

//--- src/rob.sv
`timescale 1ns/1ps

module rob (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          issue,
	input  logic [2:0]                    issue_rd,
	output logic [ooo_pkg::rob_width-1:0] issue_tag,
	output logic                          full,
	input  logic [ooo_pkg::rob_width-1:0] read_tag_a,
	input  logic [ooo_pkg::rob_width-1:0] read_tag_b,
	output ooo_pkg::cdb_t                 read_a,
	output ooo_pkg::cdb_t                 read_b,
	input  ooo_pkg::cdb_t                 cdb,
	input  ooo_pkg::commit_kind_t         commit_kind,
	output logic                          commit,
	output logic [2:0]                    commit_rd,
	output logic [ooo_pkg::rob_width-1:0] commit_tag,
	output logic [31:0]                   commit_data
);

	localparam int depth = 2 ** ooo_pkg::rob_width;

	logic [ooo_pkg::rob_width-1:0] head;
	logic [ooo_pkg::rob_width-1:0] tail;
	logic [ooo_pkg::rob_width:0]   count;
	logic [depth-1:0]              done;
	logic [2:0]                    rd [depth];
	logic [31:0]                   data [depth];

	assign issue_tag = tail;
	assign full = count[ooo_pkg::rob_width];

	// valid here means the entry already has its result
	assign read_a = '{valid: done[read_tag_a], tag: read_tag_a, data: data[read_tag_a]};
	assign read_b = '{valid: done[read_tag_b], tag: read_tag_b, data: data[read_tag_b]};

	////////////////////////////////////////////////////////////////////////////
	// in-order commit when the ring head is a gpr write

	assign commit = count != '0 && commit_kind == ooo_pkg::commit_gpr && done[head];
	assign commit_rd = rd[head];
	assign commit_tag = head;
	assign commit_data = data[head];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end else begin
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
			if (issue) begin
				done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (commit) begin
				head <= head + 1'b1;
			end
			case ({issue, commit})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cdb.valid) begin
			data[cdb.tag] <= cdb.data;
		end
		if (issue) begin
			rd[tail] <= issue_rd;
		end
	end

	a_commit_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		commit |-> head != tail || full) else $error("rob commit while empty");
	a_issue_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> !full) else $error("rob issue while full");

endmodule
